/* verilog/cache_pkg.sv */
package cache_pkg;

  // processor side widths.
  localparam int ADDR_W = 32;   // byte address.
  localparam int DATA_W = 32;   // one memory word.

  // byte offset inside a word, always dropped on the memory port.
  localparam int BYTE_OFF_W = 2;

  // commands that a single line accepts at the clock edge.
  typedef enum logic [2:0] {
    LOP_NONE    = 3'd0,  // hold contents.
    LOP_WRITE   = 3'd1,  // processor word write, marks the line dirty.
    LOP_FILL    = 3'd2,  // one refill word from memory.
    LOP_INSTALL = 3'd3   // new tag, valid set, dirty cleared.
  } line_op_e;

  // miss handling FSM states.
  typedef enum logic [1:0] {
    S_IDLE   = 2'd0,  // hits served here.
    S_WBACK  = 2'd1,  // dirty victim goes back to memory.
    S_REFILL = 2'd2   // block comes in, then the tag is installed.
  } ctrl_state_e;

endpackage

/* verilog/line_ctrl_if.sv */
`timescale 1ns/10ps

interface line_ctrl_if #(
  parameter int TAG_WIDTH    = 26,
  parameter int OFFSET_WIDTH = 4
);
  import cache_pkg::*;

  line_op_e                op;            // command for the indexed set.
  logic [OFFSET_WIDTH-3:0] word_sel;      // word offset inside the line.
  logic [TAG_WIDTH-1:0]    new_tag;       // tag written on install.
  logic                    victim_dirty;  // victim of the indexed set needs write-back.
  logic [TAG_WIDTH-1:0]    victim_tag;    // used to rebuild the write-back address.

  modport ctrl (
    output op, word_sel, new_tag,
    input  victim_dirty, victim_tag
  );

  modport array (
    input  op, word_sel, new_tag,
    output victim_dirty, victim_tag
  );

endinterface

/* verilog/cache_line.sv */
`timescale 1ns/10ps

module cache_line #(
  parameter int TAG_WIDTH    = 26,
  parameter int OFFSET_WIDTH = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  cache_pkg::line_op_e          op_i,
  input  logic [OFFSET_WIDTH-3:0]      word_sel_i,
  input  logic [cache_pkg::DATA_W-1:0] wdata_i,
  input  logic [TAG_WIDTH-1:0]         new_tag_i,
  output logic                         valid_o,
  output logic                         dirty_o,
  output logic [TAG_WIDTH-1:0]         tag_o,
  output logic [cache_pkg::DATA_W-1:0] rdata_o
);
  import cache_pkg::*;

  localparam int WORDS = 2 ** (OFFSET_WIDTH - 2);  // words per line.

  logic              valid_q;
  logic              dirty_q;
  logic [TAG_WIDTH-1:0] tag_q;
  logic [DATA_W-1:0] data_q [WORDS];

  // status bits, the only state that needs a defined value after reset.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      dirty_q <= 1'b0;
    end else begin
      case (op_i)
        LOP_WRITE:   dirty_q <= 1'b1;  // line now differs from memory.
        LOP_INSTALL: begin
          valid_q <= 1'b1;
          dirty_q <= 1'b0;  // fresh copy of the memory block.
        end
        default: ;
      endcase
    end
  end

  // tag and data words.
  always_ff @(posedge clk_i) begin
    case (op_i)
      LOP_WRITE,
      LOP_FILL:    data_q[word_sel_i] <= wdata_i;  // same path for both writers.
      LOP_INSTALL: tag_q <= new_tag_i;
      default: ;
    endcase
  end

  assign valid_o = valid_q;
  assign dirty_o = dirty_q;
  assign tag_o   = tag_q;
  assign rdata_o = data_q[word_sel_i];  // combinational word read.

endmodule

/* verilog/cache_set.sv */
`timescale 1ns/10ps

module cache_set #(
  parameter int TAG_WIDTH    = 26,
  parameter int OFFSET_WIDTH = 4,
  parameter int LINES        = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  cache_pkg::line_op_e          op_i,
  input  logic [OFFSET_WIDTH-3:0]      word_sel_i,
  input  logic [TAG_WIDTH-1:0]         tag_i,      // tag of the request.
  input  logic [cache_pkg::DATA_W-1:0] wdata_i,
  input  logic [TAG_WIDTH-1:0]         new_tag_i,
  output logic                         hit_o,
  output logic [cache_pkg::DATA_W-1:0] rdata_o,
  output logic                         victim_dirty_o,
  output logic [TAG_WIDTH-1:0]         victim_tag_o
);
  import cache_pkg::*;

  localparam int VW = (LINES > 1) ? $clog2(LINES) : 1;  // victim pointer width.

  logic [LINES-1:0]     line_valid;
  logic [LINES-1:0]     line_dirty;
  logic [LINES-1:0]     hit_vec;
  logic [TAG_WIDTH-1:0] line_tag [LINES];
  logic [DATA_W-1:0]    line_rdata [LINES];
  line_op_e             line_op [LINES];
  logic [VW-1:0]        victim_q;
  logic [VW-1:0]        hit_idx;

  // round-robin replacement, moves on once a line has been installed.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      victim_q <= '0;
    end else if (op_i == LOP_INSTALL) begin
      victim_q <= (victim_q == VW'(LINES - 1)) ? '0 : victim_q + 1'b1;
    end
  end

  // tag compare and per-line command routing.
  always_comb begin
    hit_idx = '0;
    for (int i = 0; i < LINES; i++) begin
      hit_vec[i] = line_valid[i] && (line_tag[i] == tag_i);
      if (hit_vec[i]) hit_idx = VW'(i);  // at most one way matches.
      line_op[i] = LOP_NONE;
      if (op_i == LOP_WRITE && hit_vec[i]) begin
        line_op[i] = LOP_WRITE;
      end else if ((op_i == LOP_FILL || op_i == LOP_INSTALL) && victim_q == VW'(i)) begin
        line_op[i] = op_i;  // refill always targets the victim.
      end
    end
  end

  for (genvar i = 0; i < LINES; i++) begin : g_line
    cache_line #(
      .TAG_WIDTH   (TAG_WIDTH),
      .OFFSET_WIDTH(OFFSET_WIDTH)
    ) u_line (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .op_i      (line_op[i]),
      .word_sel_i(word_sel_i),
      .wdata_i   (wdata_i),
      .new_tag_i (new_tag_i),
      .valid_o   (line_valid[i]),
      .dirty_o   (line_dirty[i]),
      .tag_o     (line_tag[i]),
      .rdata_o   (line_rdata[i])
    );
  end

  assign hit_o          = |hit_vec;
  // on a miss the victim word is shown, which is what write-back needs.
  assign rdata_o        = hit_o ? line_rdata[hit_idx] : line_rdata[victim_q];
  assign victim_dirty_o = line_dirty[victim_q];
  assign victim_tag_o   = line_tag[victim_q];

endmodule

/* verilog/cache_controller.sv */
`timescale 1ns/10ps

module cache_controller #(
  parameter int TAG_WIDTH    = 26,
  parameter int SET_WIDTH    = 2,
  parameter int OFFSET_WIDTH = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         stall_i,
  input  logic                         req_valid_i,
  input  logic                         hit_i,       // raw hit of the indexed set.
  input  logic                         we_i,
  input  logic [cache_pkg::ADDR_W-1:0] addr_i,
  line_ctrl_if.ctrl                    ctrl,
  output logic [cache_pkg::ADDR_W-1:0] mem_addr_o,
  output logic                         mem_we_o
);
  import cache_pkg::*;

  localparam int WORDS = 2 ** (OFFSET_WIDTH - 2);
  localparam int CNT_W = OFFSET_WIDTH - 1;  // one extra bit marks the install cycle.

  ctrl_state_e             state_q, state_d;
  logic [CNT_W-1:0]        cnt_q, cnt_d;
  logic [TAG_WIDTH-1:0]    req_tag;
  logic [SET_WIDTH-1:0]    req_idx;
  logic [OFFSET_WIDTH-3:0] req_off;
  logic [OFFSET_WIDTH-3:0] word;
  logic [TAG_WIDTH-1:0]    blk_tag;

  assign req_tag = addr_i[ADDR_W-1 -: TAG_WIDTH];
  assign req_idx = addr_i[OFFSET_WIDTH +: SET_WIDTH];
  assign req_off = addr_i[BYTE_OFF_W +: OFFSET_WIDTH-BYTE_OFF_W];
  assign word    = cnt_q[OFFSET_WIDTH-3:0];  // low bits walk the line.

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_comb begin
    state_d  = state_q;
    cnt_d    = cnt_q;
    ctrl.op  = LOP_NONE;
    mem_we_o = 1'b0;
    if (!stall_i) begin  // a stall freezes everything.
      case (state_q)
        S_IDLE: begin
          if (req_valid_i && hit_i && we_i) begin
            ctrl.op = LOP_WRITE;  // lands at the edge closing the hit cycle.
          end else if (req_valid_i && !hit_i) begin
            state_d = ctrl.victim_dirty ? S_WBACK : S_REFILL;
            cnt_d   = '0;
          end
        end
        S_WBACK: begin
          mem_we_o = 1'b1;
          cnt_d    = cnt_q + 1'b1;
          if (cnt_q == CNT_W'(WORDS - 1)) begin
            state_d = S_REFILL;
            cnt_d   = '0;
          end
        end
        S_REFILL: begin
          if (cnt_q == CNT_W'(WORDS)) begin
            ctrl.op = LOP_INSTALL;  // all words in, make the line valid.
            state_d = S_IDLE;
            cnt_d   = '0;
          end else begin
            ctrl.op = LOP_FILL;
            cnt_d   = cnt_q + 1'b1;
          end
        end
        default: state_d = S_IDLE;
      endcase
    end
  end

  // write-back goes to the victim's block, everything else to the request's block.
  assign blk_tag       = (state_q == S_WBACK) ? ctrl.victim_tag : req_tag;
  assign mem_addr_o    = {blk_tag, req_idx, word, {BYTE_OFF_W{1'b0}}};
  assign ctrl.word_sel = (state_q == S_IDLE) ? req_off : word;
  assign ctrl.new_tag  = req_tag;

endmodule

/* verilog/cache.sv */
`timescale 1ns/10ps

module cache #(
  parameter int TAG_WIDTH    = 26,
  parameter int SET_WIDTH    = 2,
  parameter int OFFSET_WIDTH = 4,
  parameter int LINES        = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         stall_i,
  input  logic                         req_valid_i,  // held until hit_o.
  input  logic                         we_i,
  input  logic [cache_pkg::ADDR_W-1:0] addr_i,
  input  logic [cache_pkg::DATA_W-1:0] wdata_i,
  output logic                         hit_o,
  output logic [cache_pkg::DATA_W-1:0] rdata_o,
  input  logic [cache_pkg::DATA_W-1:0] mem_rdata_i,  // combinational read data.
  output logic [cache_pkg::ADDR_W-1:0] mem_addr_o,
  output logic                         mem_we_o,
  output logic [cache_pkg::DATA_W-1:0] mem_wdata_o
);
  import cache_pkg::*;

  localparam int SETS = 2 ** SET_WIDTH;

  logic [TAG_WIDTH-1:0] req_tag;
  logic [SET_WIDTH-1:0] index;
  logic [SETS-1:0]      set_hit;
  logic [SETS-1:0]      set_vdirty;
  logic [TAG_WIDTH-1:0] set_vtag [SETS];
  logic [DATA_W-1:0]    set_rdata [SETS];
  line_op_e             set_op [SETS];
  logic [DATA_W-1:0]    set_wdata;
  logic                 idx_hit;

  assign req_tag = addr_i[ADDR_W-1 -: TAG_WIDTH];
  assign index   = addr_i[OFFSET_WIDTH +: SET_WIDTH];

  line_ctrl_if #(.TAG_WIDTH(TAG_WIDTH), .OFFSET_WIDTH(OFFSET_WIDTH)) lc ();

  cache_controller #(
    .TAG_WIDTH   (TAG_WIDTH),
    .SET_WIDTH   (SET_WIDTH),
    .OFFSET_WIDTH(OFFSET_WIDTH)
  ) u_ctrl (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .stall_i    (stall_i),
    .req_valid_i(req_valid_i),
    .hit_i      (idx_hit),
    .we_i       (we_i),
    .addr_i     (addr_i),
    .ctrl       (lc.ctrl),
    .mem_addr_o (mem_addr_o),
    .mem_we_o   (mem_we_o)
  );

  // only the indexed set sees a command.
  always_comb begin
    for (int i = 0; i < SETS; i++) begin
      set_op[i] = (i == index) ? lc.op : LOP_NONE;
    end
  end

  assign set_wdata = (lc.op == LOP_FILL) ? mem_rdata_i : wdata_i;  // refill or cpu word.

  for (genvar s = 0; s < SETS; s++) begin : g_set
    cache_set #(
      .TAG_WIDTH   (TAG_WIDTH),
      .OFFSET_WIDTH(OFFSET_WIDTH),
      .LINES       (LINES)
    ) u_set (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .op_i          (set_op[s]),
      .word_sel_i    (lc.word_sel),
      .tag_i         (req_tag),
      .wdata_i       (set_wdata),
      .new_tag_i     (lc.new_tag),
      .hit_o         (set_hit[s]),
      .rdata_o       (set_rdata[s]),
      .victim_dirty_o(set_vdirty[s]),
      .victim_tag_o  (set_vtag[s])
    );
  end

  assign lc.victim_dirty = set_vdirty[index];
  assign lc.victim_tag   = set_vtag[index];

  assign idx_hit     = set_hit[index];
  assign hit_o       = idx_hit & ~stall_i;  // no access completes while stalled.
  assign rdata_o     = set_rdata[index];
  assign mem_wdata_o = set_rdata[index];    // victim word during write-back.

endmodule

/* dv/cache_sva.sv */
`timescale 1ns/10ps

module cache_sva #(
  parameter int OFFSET_WIDTH = 4
) (
  input logic clk_i,
  input logic rst_i,
  input logic stall_i,
  input logic req_valid_i,
  input logic hit_o,
  input logic mem_we_o
);

  localparam int WORDS    = 2 ** (OFFSET_WIDTH - 2);
  localparam int MAX_WAIT = 2 * WORDS + 2;  // dirty miss, miss cycle included.

  // frozen controller leaves memory alone.
  no_write_in_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_i |-> !mem_we_o)
    else $error("mem_we_o high while stall_i is high");

  // lines are invalid from the first reset edge on.
  no_hit_in_reset: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> !hit_o)
    else $error("hit_o high during reset");

  // a stall pauses the bound, so stalled attempts are dropped.
  req_gets_hit: assert property (@(posedge clk_i) disable iff (rst_i || stall_i)
    req_valid_i |-> ##[0:MAX_WAIT] hit_o)
    else $error("request held without hit_o for too long");

endmodule

bind cache cache_sva #(.OFFSET_WIDTH(OFFSET_WIDTH)) u_sva (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .stall_i    (stall_i),
  .req_valid_i(req_valid_i),
  .hit_o      (hit_o),
  .mem_we_o   (mem_we_o)
);

/* dv/cache_tb.sv */
`timescale 1ns/10ps

module cache_tb;
  import cache_pkg::*;

  localparam int TAG_W      = 26;
  localparam int SET_W      = 2;
  localparam int OFF_W      = 4;
  localparam int LINES      = 2;
  localparam int WORDS      = 2 ** (OFF_W - 2);
  localparam int MISS_WAIT  = WORDS + 2;       // miss cycle, refill words, install.
  localparam int DIRTY_WAIT = 2 * WORDS + 2;   // write-back words come first.
  localparam int MEM_WORDS  = 4096;            // covers the 16 KB random range.
  localparam int MEM_AW     = $clog2(MEM_WORDS);
  localparam logic [31:0] MEM_XOR = 32'h5a5a_0000;
  localparam logic [31:0] SEED    = 32'h2fe0;
  localparam int N_STIM     = 11;
  localparam int N_RAND     = 200;
  localparam int STALL_CYC  = 5;
  localparam int LIMIT      = (N_STIM + N_RAND + 3) * (2 * WORDS + 3) + 100;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [7:0]        waits;  // exact wait cycles expected.
  } stim_t;

  logic              clk;
  logic              rst;
  logic              stall;
  logic              req_valid;
  logic              we;
  logic              hit;
  logic              mem_we;
  logic [ADDR_W-1:0] addr;
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;
  logic [DATA_W-1:0] mem_rdata;
  logic [DATA_W-1:0] mem_wdata;
  logic [DATA_W-1:0] mem [MEM_WORDS];  // main memory model.
  logic [DATA_W-1:0] shadow [int];     // last written value per word address.
  stim_t             stim [N_STIM];
  int                cycles;
  int                data_errs;
  int                wait_errs;
  int                ctl_errs;

  cache #(
    .TAG_WIDTH   (TAG_W),
    .SET_WIDTH   (SET_W),
    .OFFSET_WIDTH(OFF_W),
    .LINES       (LINES)
  ) DUT (
    .clk_i      (clk),
    .rst_i      (rst),
    .stall_i    (stall),
    .req_valid_i(req_valid),
    .we_i       (we),
    .addr_i     (addr),
    .wdata_i    (wdata),
    .hit_o      (hit),
    .rdata_o    (rdata),
    .mem_rdata_i(mem_rdata),
    .mem_addr_o (mem_addr),
    .mem_we_o   (mem_we),
    .mem_wdata_o(mem_wdata)
  );

  always #2 clk = ~clk;  // 4 ns period.

  assign mem_rdata = mem[mem_addr[MEM_AW+1:2]];  // combinational read.

  always @(posedge clk) begin
    if (mem_we) mem[mem_addr[MEM_AW+1:2]] <= mem_wdata;  // write at the edge.
  end

  // run limit.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, an access never completed", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic logic [DATA_W-1:0] init_word(input logic [ADDR_W-1:0] a);
    return (a >> 2) ^ MEM_XOR;  // word address xor a constant.
  endfunction

  function automatic logic [DATA_W-1:0] expect_word(input logic [ADDR_W-1:0] a);
    int k;
    k = int'(a >> 2);
    return shadow.exists(k) ? shadow[k] : init_word(a);
  endfunction

  task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      data_errs++;
      $display("ERROR @%0t: %s gave 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_wait(input int got, input int lo, input int hi,
                            input logic [ADDR_W-1:0] a);
    if (got < lo || got > hi) begin
      wait_errs++;
      $display("ERROR @%0t: addr 0x%08h waited %0d cycles, allowed %0d to %0d",
               $time, a, got, lo, hi);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      ctl_errs++;
      $display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      ctl_errs++;
      $display("ERROR @%0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // request held until hit, sampled mid-cycle.
  task automatic do_access(input logic w, input logic [ADDR_W-1:0] a,
                           input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] rd,
                           output int waits);
    @(posedge clk);
    req_valid <= 1'b1;
    we        <= w;
    addr      <= a;
    wdata     <= d;
    waits = 0;
    @(negedge clk);
    while (hit !== 1'b1) begin
      waits++;
      @(negedge clk);
    end
    rd = rdata;
  endtask

  task automatic run_access(input logic w, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input int lo, input int hi);
    logic [DATA_W-1:0] rd;
    int                waits;
    do_access(w, a, d, rd, waits);
    check_wait(waits, lo, hi, a);
    if (w)
      shadow[int'(a >> 2)] = d;  // lands at the edge closing the hit cycle.
    else
      check_word(rd, expect_word(a), $sformatf("read of 0x%08h", a));
  endtask

  // dirty miss in set 3, frozen part way through the write-back.
  task automatic stalled_miss();
    logic [ADDR_W-1:0] held;
    run_access(1'b1, 32'h0000_0830, 32'h5157_a11e, MISS_WAIT, MISS_WAIT);  // way 0, dirty.
    run_access(1'b0, 32'h0000_0870, 32'h0, MISS_WAIT, MISS_WAIT);          // way 1, clean.
    @(posedge clk);
    req_valid <= 1'b1;
    we        <= 1'b0;
    addr      <= 32'h0000_08b0;  // evicts the dirty way.
    repeat (3) @(posedge clk);
    stall <= 1'b1;
    @(negedge clk);
    held = mem_addr;
    repeat (STALL_CYC) begin
      check_bit(hit, 1'b0, "hit_o during stall");
      check_bit(mem_we, 1'b0, "mem_we_o during stall");
      check_addr(mem_addr, held, "mem_addr_o during stall");
      @(negedge clk);
    end
    @(posedge clk);
    stall <= 1'b0;
    @(negedge clk);
    while (hit !== 1'b1) @(negedge clk);
    check_word(rdata, expect_word(32'h0000_08b0), "read after stall");
    check_word(mem[int'(32'h0830 >> 2)], 32'h5157_a11e, "write-back after stall");
    @(posedge clk);
    stall <= 1'b1;  // same request again, now a hit that the stall must hide.
    @(negedge clk);
    check_bit(hit, 1'b0, "hit_o during stall on a hit");
    @(posedge clk);
    stall <= 1'b0;
    @(negedge clk);
    check_bit(hit, 1'b1, "hit_o after stall on a hit");
    check_word(rdata, expect_word(32'h0000_08b0), "read after stall on a hit");
  endtask

  initial begin
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    logic              w;
    clk       = 1'b0;
    rst       = 1'b1;
    stall     = 1'b0;
    req_valid = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    void'($urandom(SEED));  // one seed for the whole run.
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = i ^ MEM_XOR;
    // sets 0 to 2, set index is addr[5:4].
    stim = '{
      '{1'b0, 32'h0000_0100, 32'h0,          8'(MISS_WAIT)},   // first read misses.
      '{1'b0, 32'h0000_0104, 32'h0,          8'd0},
      '{1'b1, 32'h0000_0210, 32'hcafe_0001,  8'(MISS_WAIT)},
      '{1'b0, 32'h0000_0210, 32'h0,          8'd0},            // read after write hits.
      '{1'b1, 32'h0000_021c, 32'h1234_5678,  8'd0},
      '{1'b0, 32'h0000_021c, 32'h0,          8'd0},
      '{1'b1, 32'h0000_0424, 32'hdead_beef,  8'(MISS_WAIT)},   // dirty block in set 2.
      '{1'b0, 32'h0000_0460, 32'h0,          8'(MISS_WAIT)},
      '{1'b0, 32'h0000_04a0, 32'h0,          8'(DIRTY_WAIT)},  // evicts 0x420.
      '{1'b0, 32'h0000_0424, 32'h0,          8'(MISS_WAIT)},
      '{1'b0, 32'h0000_0428, 32'h0,          8'd0}
    };
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < N_STIM; i++) begin
      run_access(stim[i].we, stim[i].addr, stim[i].data, stim[i].waits, stim[i].waits);
    end
    check_word(mem[int'(32'h0424 >> 2)], 32'hdead_beef, "memory after eviction");
    stalled_miss();
    repeat (N_RAND) begin
      a = ADDR_W'($urandom_range(0, MEM_WORDS - 1)) << 2;  // word aligned, 16 KB.
      w = 1'($urandom_range(0, 1));
      d = $urandom();
      run_access(w, a, d, 0, DIRTY_WAIT);
    end
    @(posedge clk);
    req_valid <= 1'b0;
    we        <= 1'b0;
    @(posedge clk);
    $display("errors: data %0d, wait %0d, control %0d", data_errs, wait_errs, ctl_errs);
    if (data_errs + wait_errs + ctl_errs == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* sources.f */
verilog/cache_pkg.sv
verilog/line_ctrl_if.sv
verilog/cache_line.sv
verilog/cache_set.sv
verilog/cache_controller.sv
verilog/cache.sv
dv/cache_sva.sv
dv/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - verilog/cache_pkg.sv
  - verilog/line_ctrl_if.sv
  - verilog/cache_line.sv
  - verilog/cache_set.sv
  - verilog/cache_controller.sv
  - verilog/cache.sv
  - target: test
    files:
      - dv/cache_sva.sv
      - dv/cache_tb.sv
